// ==== build.f ====
+incdir+design
design/lpif_pkg.sv
design/lpif_dstrm_framer.sv
design/aib_lane.sv
design/lpif_ustrm_deframer.sv
design/lpif_lsm.sv
design/lpif_adapter.sv
tb/tb_lpif_adapter.sv

// ==== tb/lpif_input.txt ====
// lpbk fs ms sl req lerr irdy valid stream data dout exp_sts, all hex
// data ffffffff draws random data, exp_sts is pl_state_sts seen while the line is driven
1 1 f 7 1 0 1 1 01 11111111 0000000000 0
1 1 f 7 1 0 1 1 01 11111111 0000000000 0
1 1 f f 1 0 0 0 00 00000000 0000000000 0
1 1 f f 1 0 0 0 00 00000000 0000000000 0
1 1 f f 1 0 1 1 01 deadbeef 0000000000 1
1 1 f f 1 0 1 1 02 ffffffff 0000000000 1
1 1 f f 1 0 1 1 03 ffffffff 0000000000 1
1 1 f f 1 0 1 1 5a cafef00d 0000000000 1
1 1 f f 1 0 1 0 02 0badc0de 0000000000 1
1 1 f f 1 0 0 1 01 55aa55aa 0000000000 1
1 1 f f 1 0 0 0 00 00000000 0000000000 1
0 1 f f 1 0 1 1 02 0f0f0f0f 0ba5a5a5a5 1
0 1 f f 1 0 0 0 00 00000000 0d13572468 1
0 1 e f 1 0 0 0 00 00000000 0000000000 1
0 1 e f 1 0 0 0 00 00000000 0000000000 1
0 1 f f 1 0 1 1 01 77777777 0000000000 b
0 1 f f 1 0 0 0 00 00000000 0000000000 b
0 1 f f 1 0 0 0 00 00000000 5000000000 1
0 1 f f 1 0 0 0 00 00000000 0000000000 1
0 1 f f 1 0 0 0 00 00000000 0000000000 1
0 1 f f 1 0 0 0 00 00000000 0000000000 a
0 1 f f 0 0 0 0 00 00000000 0000000000 a
0 1 f f 1 0 0 0 00 00000000 0000000000 0
0 1 f f 1 1 0 0 00 00000000 0000000000 1
0 1 f f 1 0 0 0 00 00000000 0000000000 a
0 1 f f 0 0 0 0 00 00000000 0000000000 a
0 1 f f 0 0 0 0 00 00000000 0000000000 0

// ==== tb/tb_lpif_adapter.sv ====
/*
 * Testbench for the LPIF to AIB adapter
 * Replays vector lines and checks link state, lane words and returned flits
 */

`timescale 1ns/1ns
`default_nettype none

`include "lpif_defs.svh"

module tb_lpif_adapter;

  localparam int FLIT_W    = `AIB_LANES*`AIB_BITS_PER_LANE;
  localparam int DATA_W    = `LPIF_DATA_BYTES*8;
  localparam int MAX_LINES = 64;
  localparam logic [3:0] ST_ACTIVE = 4'h1;

  // One vector line
  typedef struct packed
  {
    logic                  lpbk;
    logic                  fs_rdy;
    logic [`AIB_LANES-1:0] ms_en;
    logic [`AIB_LANES-1:0] sl_en;
    logic [3:0]            req;
    logic                  lerr;
    logic                  irdy;
    logic                  valid;
    logic [7:0]            stream;
    logic [DATA_W-1:0]     data;
    logic [FLIT_W-1:0]     dout;
    logic [3:0]            sts;
  } vector_t;

  // Flit expected back on pl_*
  typedef struct packed
  {
    logic [31:0]       due;   // line it must show on
    logic [7:0]        stream;
    logic [DATA_W-1:0] data;
  } up_flit_t;

  logic                  lclk;
  logic                  rst_n;
  logic                  lp_irdy;
  logic                  lp_valid;
  logic [7:0]            lp_stream;
  logic [DATA_W-1:0]     lp_data;
  logic [3:0]            lp_state_req;
  logic                  lp_linkerror;
  logic                  pl_trdy;
  logic                  pl_valid;
  logic [7:0]            pl_stream;
  logic [DATA_W-1:0]     pl_data;
  logic [3:0]            pl_state_sts;
  logic                  pl_lnk_up;
  wire  [FLIT_W-1:0]     data_in_f;
  logic [FLIT_W-1:0]     dout;
  logic [`AIB_LANES-1:0] ms_tx_transfer_en;
  logic [`AIB_LANES-1:0] sl_rx_transfer_en;
  logic                  fs_mac_rdy;
  logic                  lpbk_en;

  vector_t           vecs [0:MAX_LINES-1];
  logic [FLIT_W-1:0] tx_exp [0:MAX_LINES+1];   // data_in_f per line
  up_flit_t          up_q [$];
  vector_t           v;
  up_flit_t          exp_up;
  logic [FLIT_W-1:0] rx_src;
  logic [31:0]       rng;
  logic              loaded;
  int                n_lines;
  int                errors;

  lpif_adapter DUT
  (
    .lclk              (lclk),
    .rst_n             (rst_n),
    .lp_irdy           (lp_irdy),
    .lp_valid          (lp_valid),
    .lp_stream         (lp_stream),
    .lp_data           (lp_data),
    .lp_state_req      (lp_state_req),
    .lp_linkerror      (lp_linkerror),
    .pl_trdy           (pl_trdy),
    .pl_valid          (pl_valid),
    .pl_stream         (pl_stream),
    .pl_data           (pl_data),
    .pl_state_sts      (pl_state_sts),
    .pl_lnk_up         (pl_lnk_up),
    .data_in_f         (data_in_f),
    .dout              (dout),
    .ms_tx_transfer_en (ms_tx_transfer_en),
    .sl_rx_transfer_en (sl_rx_transfer_en),
    .fs_mac_rdy        (fs_mac_rdy),
    .lpbk_en           (lpbk_en)
  );

  ////////////////////////////////////////
  // Reference helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [1:0] prot_of_stream(input logic [7:0] s);
    case (s)
      `MEM_CACHE_STREAM_ID: return 2'd0;
      `IO_STREAM_ID:        return 2'd1;
      `ARB_MUX_STREAM_ID:   return 2'd2;
      default:              return 2'd3;   // unknown stream
    endcase
  endfunction

  function automatic logic [7:0] stream_of_prot(input logic [1:0] p);
    case (p)
      2'd0:    return `MEM_CACHE_STREAM_ID;
      2'd1:    return `IO_STREAM_ID;
      2'd2:    return `ARB_MUX_STREAM_ID;
      default: return 8'h00;
    endcase
  endfunction

  // Pad, state, protid, valid, data from the top bit down
  function automatic logic [FLIT_W-1:0] build_flit(input logic [3:0] st, input logic [1:0] p,
                                                   input logic vld, input logic [DATA_W-1:0] d);
    return {1'b0, st, p, vld, d};
  endfunction

  task read_vectors;
    int                fd;
    int                cnt;
    logic [8*160-1:0]  text;
    logic [FLIT_W-1:0] col [0:11];
    fd = $fopen("tb/lpif_input.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file tb/lpif_input.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd) && n_lines < MAX_LINES)
      begin
        text = '0;
        cnt  = $fgets(text, fd);
        if (cnt > 0)
          cnt = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                        col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9],
                        col[10], col[11]);
        if (cnt == 12)   // comment and blank lines fall through
        begin
          vecs[n_lines].lpbk   = col[0][0];
          vecs[n_lines].fs_rdy = col[1][0];
          vecs[n_lines].ms_en  = col[2][`AIB_LANES-1:0];
          vecs[n_lines].sl_en  = col[3][`AIB_LANES-1:0];
          vecs[n_lines].req    = col[4][3:0];
          vecs[n_lines].lerr   = col[5][0];
          vecs[n_lines].irdy   = col[6][0];
          vecs[n_lines].valid  = col[7][0];
          vecs[n_lines].stream = col[8][7:0];
          vecs[n_lines].data   = col[9][DATA_W-1:0];
          vecs[n_lines].dout   = col[10];
          vecs[n_lines].sts    = col[11][3:0];
          if (col[9][DATA_W-1:0] == 32'hffffffff)   // random data marker
          begin
            rng                = xorshift32(rng);
            vecs[n_lines].data = rng;
          end
          n_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial
  begin
    lclk = 1'b0;
    forever #5 lclk = ~lclk;
  end

  initial
  begin
    wait (loaded);
    #((n_lines + 23) * 10);   // reset, all lines, then slack
    $display("Timeout: the run did not finish in %0d cycles", n_lines + 23);
    $display("Verification failed");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////

  initial
  begin
    rst_n             = 1'b0;
    lp_irdy           = 1'b0;
    lp_valid          = 1'b0;
    lp_stream         = '0;
    lp_data           = '0;
    lp_state_req      = '0;
    lp_linkerror      = 1'b0;
    dout              = '0;
    ms_tx_transfer_en = '0;
    sl_rx_transfer_en = '0;
    fs_mac_rdy        = 1'b0;
    lpbk_en           = 1'b0;
    errors            = 0;
    n_lines           = 0;
    loaded            = 1'b0;
    rng               = 32'h86cf;
    tx_exp[0]         = '0;   // reset flits
    tx_exp[1]         = '0;
    read_vectors();
    loaded = 1'b1;
    if (n_lines == 0)
    begin
      $display("No vector lines were read");
      errors++;
    end
    repeat (3) @(posedge lclk);
    rst_n <= 1'b1;
    for (int k = 0; k < n_lines; k++)
    begin
      @(posedge lclk);
      v = vecs[k];
      lpbk_en           <= v.lpbk;
      fs_mac_rdy        <= v.fs_rdy;
      ms_tx_transfer_en <= v.ms_en;
      sl_rx_transfer_en <= v.sl_en;
      lp_state_req      <= v.req;
      lp_linkerror      <= v.lerr;
      lp_irdy           <= v.irdy;
      lp_valid          <= v.valid;
      lp_stream         <= v.stream;
      lp_data           <= v.data;
      dout              <= v.dout;
      // Accepted only while ACTIVE, every flit carries the local state
      if (v.irdy && v.valid && (v.sts == ST_ACTIVE))
        tx_exp[k+2] = build_flit(v.sts, prot_of_stream(v.stream), 1'b1, v.data);
      else
        tx_exp[k+2] = build_flit(v.sts, 2'd0, 1'b0, '0);
      rx_src = v.lpbk ? tx_exp[k] : v.dout;   // word the lanes capture next
      if (rx_src[32])
        up_q.push_back({k + 2, stream_of_prot(rx_src[34:33]), rx_src[31:0]});

      @(negedge lclk);
      if (pl_state_sts !== v.sts)
      begin
        $display("ERR line %0d pl_state_sts exp %h got %h", k, v.sts, pl_state_sts);
        errors++;
      end
      if (pl_trdy !== (v.sts == ST_ACTIVE))
      begin
        $display("ERR line %0d pl_trdy exp %h got %h", k, v.sts == ST_ACTIVE, pl_trdy);
        errors++;
      end
      if (pl_lnk_up !== (v.sts == ST_ACTIVE))
      begin
        $display("ERR line %0d pl_lnk_up exp %h got %h", k, v.sts == ST_ACTIVE, pl_lnk_up);
        errors++;
      end
      if (data_in_f !== tx_exp[k])
      begin
        $display("ERR line %0d data_in_f exp %h got %h", k, tx_exp[k], data_in_f);
        errors++;
      end
      if (pl_valid === 1'b1)
      begin
        if (up_q.size() == 0)
        begin
          $display("Line %0d: pl_valid is high with no flit outstanding", k);
          errors++;
        end
        else
        begin
          exp_up = up_q.pop_front();
          if (exp_up.due != k)
          begin
            $display("Line %0d: flit arrived, but it was due on line %0d", k, exp_up.due);
            errors++;
          end
          if (pl_stream !== exp_up.stream)
          begin
            $display("ERR line %0d pl_stream exp %h got %h", k, exp_up.stream, pl_stream);
            errors++;
          end
          if (pl_data !== exp_up.data)
          begin
            $display("ERR line %0d pl_data exp %h got %h", k, exp_up.data, pl_data);
            errors++;
          end
        end
      end
      else if (up_q.size() != 0)
      begin
        exp_up = up_q[0];
        if (exp_up.due <= k)
        begin
          $display("Line %0d: a flit due on this line did not arrive", k);
          exp_up = up_q.pop_front();
          errors++;
        end
      end
    end
    if (up_q.size() != 0)
    begin
      $display("%0d returned flits never arrived", up_q.size());
      errors++;
    end
    $display("Ran %0d vector lines, %0d errors", n_lines, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/lpif_adapter.sv ====
/*
 * LPIF to AIB adapter top
 * Framer, four AIB lanes, deframer and link state machine
 */

`timescale 1ns/1ns
`default_nettype none

`include "lpif_defs.svh"

module lpif_adapter
(
  input  logic                                      lclk,
  input  logic                                      rst_n,

  // LPIF, link layer to adapter
  input  logic                                      lp_irdy,
  input  logic                                      lp_valid,
  input  logic [7:0]                                lp_stream,
  input  logic [`LPIF_DATA_BYTES*8-1:0]             lp_data,
  input  logic [3:0]                                lp_state_req,
  input  logic                                      lp_linkerror,

  // LPIF, adapter to link layer
  output logic                                      pl_trdy,
  output logic                                      pl_valid,
  output logic [7:0]                                pl_stream,
  output logic [`LPIF_DATA_BYTES*8-1:0]             pl_data,
  output logic [3:0]                                pl_state_sts,
  output logic                                      pl_lnk_up,

  // AIB
  output wire  [`AIB_LANES*`AIB_BITS_PER_LANE-1:0]  data_in_f,
  input  logic [`AIB_LANES*`AIB_BITS_PER_LANE-1:0]  dout,
  input  logic [`AIB_LANES-1:0]                     ms_tx_transfer_en,
  input  logic [`AIB_LANES-1:0]                     sl_rx_transfer_en,
  input  logic                                      fs_mac_rdy,
  input  logic                                      lpbk_en
);

  import lpif_pkg::*;

  aib_flit_t                tx_flit;
  wire aib_flit_t           rx_flit;      // one slice per lane
  wire [`AIB_LANES-1:0]     lane_ready;
  lsm_state_e               remote_state;
  lsm_state_e               link_state;

  ////////////////////////////////////////
  // Downstream
  ////////////////////////////////////////

  lpif_dstrm_framer u_framer
  (
    .lclk       (lclk),
    .rst_n      (rst_n),
    .lp_irdy    (lp_irdy),
    .lp_valid   (lp_valid),
    .lp_stream  (lp_stream),
    .lp_data    (lp_data),
    .link_state (link_state),
    .pl_trdy    (pl_trdy),
    .tx_flit    (tx_flit)
  );

  ////////////////////////////////////////
  // AIB lanes
  ////////////////////////////////////////

  genvar i;
  generate
    for (i = 0; i < `AIB_LANES; i++)
    begin : g_lane
      aib_lane u_lane
      (
        .lclk              (lclk),
        .rst_n             (rst_n),
        .lpbk_en           (lpbk_en),
        .tx_word           (tx_flit[i*`AIB_BITS_PER_LANE +: `AIB_BITS_PER_LANE]),
        .dout_word         (dout[i*`AIB_BITS_PER_LANE +: `AIB_BITS_PER_LANE]),
        .ms_tx_transfer_en (ms_tx_transfer_en[i]),
        .sl_rx_transfer_en (sl_rx_transfer_en[i]),
        .data_in_f_word    (data_in_f[i*`AIB_BITS_PER_LANE +: `AIB_BITS_PER_LANE]),
        .rx_word           (rx_flit[i*`AIB_BITS_PER_LANE +: `AIB_BITS_PER_LANE]),
        .lane_ready        (lane_ready[i])
      );
    end
  endgenerate

  ////////////////////////////////////////
  // Upstream and link control
  ////////////////////////////////////////

  lpif_ustrm_deframer u_deframer
  (
    .lclk         (lclk),
    .rst_n        (rst_n),
    .rx_flit      (rx_flit),
    .pl_valid     (pl_valid),
    .pl_stream    (pl_stream),
    .pl_data      (pl_data),
    .remote_state (remote_state)
  );

  lpif_lsm u_lsm
  (
    .lclk         (lclk),
    .rst_n        (rst_n),
    .lp_state_req (lp_state_req),
    .lp_linkerror (lp_linkerror),
    .fs_mac_rdy   (fs_mac_rdy),
    .lane_ready   (lane_ready),
    .remote_state (remote_state),
    .link_state   (link_state),
    .pl_state_sts (pl_state_sts),
    .pl_lnk_up    (pl_lnk_up)
  );

endmodule

`default_nettype wire

// ==== design/lpif_lsm.sv ====
/*
 * Link state machine
 * Reset, Active, Retrain and LinkError states with link-up status
 */

`timescale 1ns/1ns
`default_nettype none

`include "lpif_defs.svh"

module lpif_lsm
(
  input  logic                  lclk,
  input  logic                  rst_n,
  input  logic [3:0]            lp_state_req,
  input  logic                  lp_linkerror,
  input  logic                  fs_mac_rdy,
  input  logic [`AIB_LANES-1:0] lane_ready,
  input  lpif_pkg::lsm_state_e  remote_state,
  output lpif_pkg::lsm_state_e  link_state,
  output logic [3:0]            pl_state_sts,
  output logic                  pl_lnk_up
);

  import lpif_pkg::*;

  lsm_state_e state;
  lsm_state_e next_state;
  logic       link_rdy;
  logic       req_active;
  logic       req_retrain;
  logic       req_reset;

  // Far side up and every lane enabled
  assign link_rdy = fs_mac_rdy & (&lane_ready);

  assign req_active  = (lp_state_req == ACTIVE);
  assign req_retrain = (lp_state_req == RETRAIN);
  assign req_reset   = (lp_state_req == RESET);

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    case (state)
      RESET:
      begin
        if (req_active && link_rdy)
          next_state = ACTIVE;
      end
      ACTIVE:
      begin
        // Errors win over retrain
        if (lp_linkerror || (remote_state == LINKERROR))
          next_state = LINKERROR;
        else if (req_retrain || !link_rdy)
          next_state = RETRAIN;
      end
      RETRAIN:
      begin
        if (link_rdy && req_active)
          next_state = ACTIVE;
      end
      LINKERROR:
      begin
        if (req_reset)   // only a reset request clears an error
          next_state = RESET;
      end
      default: next_state = RESET;
    endcase
  end

  always_ff @(posedge lclk)
  begin
    if (!rst_n)
      state <= RESET;
    else
      state <= next_state;
  end

  ////////////////////////////////////////
  // Status outputs
  ////////////////////////////////////////

  assign link_state   = state;
  assign pl_state_sts = state;             // straight from the state register
  assign pl_lnk_up    = (state == ACTIVE);

endmodule

`default_nettype wire

// ==== design/lpif_ustrm_deframer.sv ====
/*
 * Upstream deframer
 * Decodes received flits onto the pl_* outputs and extracts the remote state
 */

`timescale 1ns/1ns
`default_nettype none

`include "lpif_defs.svh"

module lpif_ustrm_deframer
(
  input  logic                          lclk,
  input  logic                          rst_n,
  input  lpif_pkg::aib_flit_t           rx_flit,
  output logic                          pl_valid,
  output logic [7:0]                    pl_stream,
  output logic [`LPIF_DATA_BYTES*8-1:0] pl_data,
  output lpif_pkg::lsm_state_e          remote_state
);

  import lpif_pkg::*;

  logic [7:0] map_stream;

  // Protocol ID back to stream ID
  always_comb
  begin
    case (rx_flit.protid)
      PROT_MEM: map_stream = `MEM_CACHE_STREAM_ID;
      PROT_IO:  map_stream = `IO_STREAM_ID;
      PROT_ARB: map_stream = `ARB_MUX_STREAM_ID;
      default:  map_stream = `NULL_STREAM_ID;   // PROT_NONE
    endcase
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge lclk)
  begin
    if (!rst_n)
    begin
      pl_valid     <= 1'b0;
      pl_stream    <= '0;
      pl_data      <= '0;
      remote_state <= RESET;
    end
    else
    begin
      pl_valid     <= rx_flit.valid;
      pl_stream    <= rx_flit.valid ? map_stream : `NULL_STREAM_ID;  // quiet when idle
      pl_data      <= rx_flit.data;
      remote_state <= rx_flit.state;
    end
  end

endmodule

`default_nettype wire

// ==== design/aib_lane.sv ====
/*
 * One AIB lane
 * Transmit register, loopback select, receive register and readiness
 */

`timescale 1ns/1ns
`default_nettype none

`include "lpif_defs.svh"

module aib_lane
(
  input  logic                          lclk,
  input  logic                          rst_n,
  input  logic                          lpbk_en,
  input  logic [`AIB_BITS_PER_LANE-1:0] tx_word,
  input  logic [`AIB_BITS_PER_LANE-1:0] dout_word,
  input  logic                          ms_tx_transfer_en,
  input  logic                          sl_rx_transfer_en,
  output logic [`AIB_BITS_PER_LANE-1:0] data_in_f_word,
  output logic [`AIB_BITS_PER_LANE-1:0] rx_word,
  output logic                          lane_ready
);

  ////////////////////////////////////////
  // Transmit side
  ////////////////////////////////////////

  always_ff @(posedge lclk)
  begin
    if (!rst_n)
      data_in_f_word <= '0;
    else
      data_in_f_word <= tx_word;
  end

  ////////////////////////////////////////
  // Receive side
  ////////////////////////////////////////

  // Loopback returns this lane's own transmit word
  always_ff @(posedge lclk)
  begin
    if (!rst_n)
      rx_word <= '0;
    else if (lpbk_en)
      rx_word <= data_in_f_word;
    else
      rx_word <= dout_word;
  end

  // Both directions must be enabled
  always_ff @(posedge lclk)
  begin
    if (!rst_n)
      lane_ready <= 1'b0;
    else
      lane_ready <= ms_tx_transfer_en & sl_rx_transfer_en;
  end

endmodule

`default_nettype wire

// ==== design/lpif_dstrm_framer.sv ====
/*
 * Downstream framer
 * Takes LPIF transfers, maps the stream ID and registers one flit per cycle
 */

`timescale 1ns/1ns
`default_nettype none

`include "lpif_defs.svh"

module lpif_dstrm_framer
(
  input  logic                          lclk,
  input  logic                          rst_n,
  input  logic                          lp_irdy,
  input  logic                          lp_valid,
  input  logic [7:0]                    lp_stream,
  input  logic [`LPIF_DATA_BYTES*8-1:0] lp_data,
  input  lpif_pkg::lsm_state_e          link_state,
  output logic                          pl_trdy,
  output lpif_pkg::aib_flit_t           tx_flit
);

  import lpif_pkg::*;

  logic      xfer_valid;
  protid_e   map_protid;
  aib_flit_t next_flit;

  // Link layer may only push while the link is up
  assign pl_trdy = (link_state == ACTIVE);

  assign xfer_valid = lp_irdy & pl_trdy & lp_valid;

  // Stream ID to protocol ID
  always_comb
  begin
    case (lp_stream)
      `MEM_CACHE_STREAM_ID: map_protid = PROT_MEM;
      `IO_STREAM_ID:        map_protid = PROT_IO;
      `ARB_MUX_STREAM_ID:   map_protid = PROT_ARB;
      default:              map_protid = PROT_NONE;
    endcase
  end

  ////////////////////////////////////////
  // Flit build
  ////////////////////////////////////////

  always_comb
  begin
    next_flit       = '0;           // idle unless a valid transfer
    next_flit.state = link_state;   // local state rides on every flit
    if (xfer_valid)
    begin
      next_flit.valid  = 1'b1;
      next_flit.protid = map_protid;
      next_flit.data   = lp_data;
    end
  end

  // One flit per cycle, idle or not
  always_ff @(posedge lclk)
  begin
    if (!rst_n)
      tx_flit <= '0;
    else
      tx_flit <= next_flit;
  end

endmodule

`default_nettype wire

// ==== design/lpif_pkg.sv ====
/*
 * LPIF adapter types
 * Link states, protocol IDs and the flit carried across the AIB lanes
 */

`default_nettype none

`include "lpif_defs.svh"

package lpif_pkg;

  ////////////////////////////////////////
  // Link state
  ////////////////////////////////////////

  // Encoding matches pl_state_sts / lp_state_req
  typedef enum logic [3:0]
  {
    RESET     = 4'h0,
    ACTIVE    = 4'h1,
    LINKERROR = 4'hA,
    RETRAIN   = 4'hB
  } lsm_state_e;

  ////////////////////////////////////////
  // Protocol ID
  ////////////////////////////////////////

  typedef enum logic [1:0]
  {
    PROT_MEM  = 2'd0,  // mem/cache stream
    PROT_IO   = 2'd1,  // I/O stream
    PROT_ARB  = 2'd2,  // ARB/MUX stream
    PROT_NONE = 2'd3   // unknown stream ID
  } protid_e;

  ////////////////////////////////////////
  // Flit on the lanes, 40 bits
  ////////////////////////////////////////

  // Lane i carries bits [10i+9:10i]
  typedef struct packed
  {
    logic                         pad;     // always zero
    lsm_state_e                   state;   // sender's link state
    protid_e                      protid;
    logic                         valid;   // low for an idle flit
    logic [`LPIF_DATA_BYTES*8-1:0] data;
  } aib_flit_t;

endpackage

`default_nettype wire

// ==== design/lpif_defs.svh ====
/*
 * LPIF adapter build constants
 * Lane geometry, LPIF data width and stream IDs
 */

`ifndef LPIF_DEFS_SVH
`define LPIF_DEFS_SVH

////////////////////////////////////////
// AIB lane geometry
////////////////////////////////////////

`define AIB_LANES           4
`define AIB_BITS_PER_LANE   10   // 4 lanes x 10 bits hold one 40-bit flit

////////////////////////////////////////
// LPIF side
////////////////////////////////////////

`define LPIF_DATA_BYTES     4    // 32-bit lp_data / pl_data

// Stream IDs seen on lp_stream and pl_stream
`define MEM_CACHE_STREAM_ID 8'h01
`define IO_STREAM_ID        8'h02
`define ARB_MUX_STREAM_ID   8'h03

// Unmapped protocol ID comes back on this stream
`define NULL_STREAM_ID      8'h00

`endif
